// File: hdl/gac_consts.svh
// widths, module ids, flit tags, action codes, fifo depths and field positions
`ifndef GAC_CONSTS_SVH
`define GAC_CONSTS_SVH

// datapath widths
`define GAC_FLIT_W      134
`define GAC_MD_W        128
`define GAC_CPUID_W     6
`define GAC_TBL_DW      32
`define GAC_TBL_AW      8
`define GAC_CFG_AW      16

// module ids in the pipeline
`define GAC_LMID        8'd4
`define GAC_NMID        8'd5

// flit tag field
`define GAC_FLIT_TAG    133:132
`define GAC_FLIT_HEAD   133:128
`define GAC_TAG_TAIL    2'b10

// action entry types
`define GAC_ACT_CPU     4'd1
`define GAC_ACT_POLL    4'd2
`define GAC_ACT_PORT    4'd3
`define GAC_ACT_MID     4'd4

// fifo sizing
`define GAC_DATA_DEPTH  1024
`define GAC_DATA_ALF    512
`define GAC_MD_DEPTH    256

// metadata fields
`define GAC_MD_PKTSRC   127
`define GAC_MD_PKTDST   126
`define GAC_MD_INPORT   125:120
`define GAC_MD_OUTTYPE  119:118
`define GAC_MD_OUTPORT  117:112
`define GAC_MD_PRIO     111:109
`define GAC_MD_DISCARD  108
`define GAC_MD_DMID     87:80
`define GAC_MD_INDEX    57:50

// local bus word address bits
`define GAC_CFG_WADDR   9:2

`endif

// File: hdl/gac_pkg.sv
// flit, metadata and cpu id types plus the two views of an action table entry
`include "gac_consts.svh"

package gac_pkg;

	typedef logic [`GAC_FLIT_W-1:0] flit_t;
	typedef logic [`GAC_MD_W-1:0] md_t;
	typedef logic [`GAC_CPUID_W-1:0] cpuid_t;

	// ******************************************************************
	// action table entry
	// ******************************************************************

	// entry for cpu and port actions
	typedef struct packed {
		logic [3:0] act_type;   // 31:28
		logic [21:0] rsvd;
		cpuid_t outport;        // 5:0
	} act_port_t;

	// entry for the mid assignment action
	typedef struct packed {
		logic [3:0] act_type;   // 31:28
		logic [19:0] rsvd;
		logic [7:0] dmid;       // 7:0
	} act_mid_t;

	// the same 32-bit word, decoded by act_type
	typedef union packed {
		act_port_t port;
		act_mid_t mid;
	} act_word_u;

endpackage

// File: hdl/gac_sync_fifo.sv
// synchronous show-ahead fifo with empty, full and almost-full flags
module gac_sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16,
	parameter int ALF_LEVEL = 8
) (
	input logic clk,
	input logic rst_n,
	input logic wr,
	input logic [WIDTH-1:0] wdata,
	input logic rd,
	output logic [WIDTH-1:0] rdata,
	output logic empty,
	output logic full,
	output logic alf
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [0:DEPTH-1];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr & ~full;
	assign do_rd = rd & ~empty;

	assign empty = (count == '0);
	assign full = (count == DEPTH);
	assign alf = (count >= ALF_LEVEL);

	assign rdata = mem[rd_ptr]; // head word shows ahead

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// upstream must honour full and the reader must honour empty
	a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n) wr |-> !full);
	a_no_rd_empty: assert property (@(posedge clk) disable iff (!rst_n) rd |-> !empty);

endmodule

// File: hdl/gac_cfg.sv
// local bus fsm with cs synchronizer and action table write/read sequencing
`include "gac_consts.svh"

module gac_cfg (
	input logic clk,
	input logic rst_n,
	input logic cfg_cs,
	input logic cfg_rw,                         // low selects write
	input logic [`GAC_CFG_AW-1:0] cfg_addr,
	input logic [`GAC_TBL_DW-1:0] cfg_wdata,
	input logic [`GAC_TBL_DW-1:0] tbl_rdata,
	output logic cfg_ack,
	output logic [`GAC_TBL_DW-1:0] cfg_rdata,
	output logic tbl_wr,
	output logic [`GAC_TBL_AW-1:0] tbl_addr,
	output logic [`GAC_TBL_DW-1:0] tbl_wdata
);

	localparam logic [2:0] R_IDLE_S = 3'd0;
	localparam logic [2:0] R_WRITE_S = 3'd1;
	localparam logic [2:0] R_READ_S = 3'd2;
	localparam logic [2:0] R_WAIT_S = 3'd3;
	localparam logic [2:0] R_ACK_S = 3'd4;

	logic [1:0] cs_sync;
	logic cs;
	logic [2:0] state;

	assign cs = cs_sync[1];

	// two flops on the chip select
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cs_sync <= 2'b00;
		end else begin
			cs_sync <= {cs_sync[0], cfg_cs};
		end
	end

	// bus address and write data latched when a cycle starts
	always_ff @(posedge clk) begin
		if ((state == R_IDLE_S) && cs) begin
			tbl_addr <= cfg_addr[`GAC_CFG_WADDR];
			if (!cfg_rw) begin
				tbl_wdata <= cfg_wdata;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= R_IDLE_S;
			cfg_ack <= 1'b0;
			cfg_rdata <= '0;
			tbl_wr <= 1'b0;
		end else begin
			case (state)
				R_IDLE_S: begin
					cfg_ack <= 1'b0;
					cfg_rdata <= '0;
					if (cs && !cfg_rw) begin
						tbl_wr <= 1'b1;
						cfg_ack <= 1'b1; // write acks at once
						state <= R_WRITE_S;
					end else if (cs) begin
						state <= R_READ_S;
					end
				end
				R_WRITE_S: begin
					tbl_wr <= 1'b0;
					state <= R_ACK_S;
				end
				R_READ_S: state <= R_WAIT_S; // ram samples tbl_addr
				R_WAIT_S: begin
					cfg_rdata <= tbl_rdata;
					cfg_ack <= 1'b1;
					state <= R_ACK_S;
				end
				R_ACK_S: begin
					cfg_ack <= cs; // hold until the master lets go
					if (!cs) begin
						state <= R_IDLE_S;
					end
				end
				default: begin
					tbl_wr <= 1'b0;
					cfg_ack <= 1'b0;
					state <= R_IDLE_S;
				end
			endcase
		end
	end

	a_wr_pulse: assert property (@(posedge clk) disable iff (!rst_n) tbl_wr |=> !tbl_wr);

endmodule

// File: hdl/gac_action_ram.sv
// 256x32 action table with a config read/write port and a lookup read port
`include "gac_consts.svh"

module gac_action_ram (
	input logic clk,
	input logic cfg_wr,
	input logic [`GAC_TBL_AW-1:0] cfg_addr,
	input logic [`GAC_TBL_DW-1:0] cfg_wdata,
	input logic [`GAC_TBL_AW-1:0] lookup_addr,
	output logic [`GAC_TBL_DW-1:0] cfg_rdata,
	output gac_pkg::act_word_u lookup_rdata
);

	logic [`GAC_TBL_DW-1:0] mem [0:(1 << `GAC_TBL_AW)-1];

	// ******************************************************************
	// config port
	// ******************************************************************
	always_ff @(posedge clk) begin
		if (cfg_wr) begin
			mem[cfg_addr] <= cfg_wdata;
		end
		cfg_rdata <= mem[cfg_addr]; // read before write
	end

	// ******************************************************************
	// lookup port
	// ******************************************************************
	always_ff @(posedge clk) begin
		lookup_rdata <= mem[lookup_addr];
	end

	a_wr_addr_known: assert property (@(posedge clk)
		cfg_wr |-> !$isunknown(cfg_addr) && !$isunknown(lookup_addr));

endmodule

// File: hdl/gac_exec.sv
// action match and execution fsm, metadata rewrite and polling cpu id
`include "gac_consts.svh"

module gac_exec (
	input logic clk,
	input logic rst_n,
	input gac_pkg::cpuid_t sys_max_cpuid,
	input logic vfifo_empty,
	input logic md_empty,
	input gac_pkg::md_t md,
	input gac_pkg::flit_t dfifo_rdata,
	input logic out_alf,
	input gac_pkg::act_word_u act,
	output logic vfifo_rd,
	output logic md_rd,
	output logic dfifo_rd,
	output logic [`GAC_TBL_AW-1:0] lookup_addr,
	output gac_pkg::flit_t out_data,
	output logic out_data_wr,
	output logic out_valid_wr
);

	import gac_pkg::*;

	localparam logic [2:0] IDLE_S = 3'd0;
	localparam logic [2:0] LOOKUP_S = 3'd1;
	localparam logic [2:0] WAIT_S = 3'd2;
	localparam logic [2:0] META_S = 3'd3;
	localparam logic [2:0] TRANS_S = 3'd4;
	localparam logic [2:0] DISCARD_S = 3'd5;

	logic [2:0] state;
	logic pkt_start;
	logic local_hit;
	logic tail;
	logic keep;
	md_t md_new;
	flit_t md_flit;
	cpuid_t polling_cpuid;

	assign pkt_start = !vfifo_empty && !md_empty && !out_alf; // out_alf only looked at here
	assign local_hit = (md[`GAC_MD_DMID] == `GAC_LMID);
	assign tail = (dfifo_rdata[`GAC_FLIT_TAG] == `GAC_TAG_TAIL);

	// pass-through pops md at the start, lookup pops it after the rewrite
	assign vfifo_rd = ((state == IDLE_S) && pkt_start && !local_hit) || (state == META_S);
	assign md_rd = vfifo_rd;
	assign dfifo_rd = (state == TRANS_S) || (state == DISCARD_S);

	// ******************************************************************
	// metadata rewrite
	// ******************************************************************
	always_comb begin
		md_new = md;
		keep = 1'b1;
		case (act.port.act_type)
			`GAC_ACT_CPU: begin
				md_new[`GAC_MD_PKTDST] = 1'b1;
				md_new[`GAC_MD_OUTTYPE] = act.port.act_type[1:0];
				md_new[`GAC_MD_OUTPORT] = act.port.outport; // port from the entry
				md_new[`GAC_MD_DMID] = `GAC_NMID;
			end
			`GAC_ACT_POLL: begin
				md_new[`GAC_MD_PKTDST] = 1'b1;
				md_new[`GAC_MD_OUTTYPE] = act.port.act_type[1:0];
				md_new[`GAC_MD_OUTPORT] = polling_cpuid;
				md_new[`GAC_MD_DMID] = `GAC_NMID;
			end
			`GAC_ACT_PORT: begin
				md_new[`GAC_MD_PKTDST] = 1'b0;
				md_new[`GAC_MD_OUTTYPE] = 2'b00;
				md_new[`GAC_MD_OUTPORT] = act.port.outport;
				md_new[`GAC_MD_DMID] = `GAC_NMID;
			end
			`GAC_ACT_MID: begin
				md_new[`GAC_MD_PKTDST] = 1'b1;
				md_new[`GAC_MD_OUTTYPE] = 2'b00;
				md_new[`GAC_MD_DMID] = act.mid.dmid; // outport kept
			end
			default: keep = 1'b0; // drop the packet
		endcase
	end

	assign md_flit = {dfifo_rdata[`GAC_FLIT_HEAD], md_new}; // head bits from first flit

	// ******************************************************************
	// control fsm
	// ******************************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE_S;
			lookup_addr <= '0;
			out_data_wr <= 1'b0;
			out_valid_wr <= 1'b0;
			polling_cpuid <= '0;
		end else begin
			out_data_wr <= 1'b0;
			out_valid_wr <= 1'b0;
			case (state)
				IDLE_S: begin
					if (pkt_start && local_hit) begin
						lookup_addr <= md[`GAC_MD_INDEX];
						state <= LOOKUP_S;
					end else if (pkt_start) begin
						state <= TRANS_S;
					end
				end
				LOOKUP_S: state <= WAIT_S;
				WAIT_S: state <= META_S;  // entry valid from here
				META_S: begin
					if (keep) begin
						out_data_wr <= 1'b1;
						state <= TRANS_S;
					end else begin
						state <= DISCARD_S;
					end
					if (act.port.act_type == `GAC_ACT_POLL) begin
						// wrap before reaching sys_max_cpuid
						if (({1'b0, polling_cpuid} + 7'd1) < {1'b0, sys_max_cpuid}) begin
							polling_cpuid <= polling_cpuid + 1'b1;
						end else begin
							polling_cpuid <= '0;
						end
					end
				end
				TRANS_S: begin
					out_data_wr <= 1'b1;
					if (tail) begin
						out_valid_wr <= 1'b1;
						state <= IDLE_S;
					end
				end
				DISCARD_S: begin
					if (tail) begin
						state <= IDLE_S;
					end
				end
				default: state <= IDLE_S;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == META_S) begin
			out_data <= md_flit;
		end else if (state == TRANS_S) begin
			out_data <= dfifo_rdata;
		end
	end

	a_valid_on_tail: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid_wr |-> out_data_wr && (out_data[`GAC_FLIT_TAG] == `GAC_TAG_TAIL));
	a_vfifo_rd: assert property (@(posedge clk) disable iff (!rst_n) vfifo_rd |-> !vfifo_empty);
	a_md_rd: assert property (@(posedge clk) disable iff (!rst_n) md_rd |-> !md_empty);

endmodule

// File: hdl/gac_top.sv
// action stage top with input fifos, local bus config, action table and executor
`include "gac_consts.svh"

module gac_top (
	input logic clk,
	input logic rst_n,
	input gac_pkg::cpuid_t sys_max_cpuid,
	// packet input
	input gac_pkg::flit_t in_data,
	input logic in_data_wr,
	input logic in_valid_wr,
	input gac_pkg::md_t in_md,
	input logic in_md_wr,
	output logic data_alf,
	output logic md_alf,
	// packet output
	output gac_pkg::flit_t out_data,
	output logic out_data_wr,
	output logic out_valid_wr,
	input logic out_alf,
	// local bus
	input logic cfg_cs,
	input logic cfg_rw,
	input logic [`GAC_CFG_AW-1:0] cfg_addr,
	input logic [`GAC_TBL_DW-1:0] cfg_wdata,
	output logic cfg_ack,
	output logic [`GAC_TBL_DW-1:0] cfg_rdata
);

	import gac_pkg::*;

	logic dfifo_rd;
	flit_t dfifo_rdata;
	logic vfifo_rd;
	logic vfifo_empty;
	logic md_rd;
	md_t md_head;
	logic md_empty;
	logic tbl_wr;
	logic [`GAC_TBL_AW-1:0] tbl_waddr;
	logic [`GAC_TBL_DW-1:0] tbl_wdata;
	logic [`GAC_TBL_DW-1:0] tbl_cfg_rdata;
	logic [`GAC_TBL_AW-1:0] tbl_lookup_addr;
	act_word_u tbl_lookup_rdata;

	// ******************************************************************
	// input queues
	// ******************************************************************
	gac_sync_fifo #(
		.WIDTH(`GAC_FLIT_W),
		.DEPTH(`GAC_DATA_DEPTH),
		.ALF_LEVEL(`GAC_DATA_ALF)
	) data_fifo_i (
		.clk(clk), .rst_n(rst_n),
		.wr(in_data_wr), .wdata(in_data), .rd(dfifo_rd), .rdata(dfifo_rdata),
		.empty(), .full(), .alf(data_alf)
	);

	// one entry per complete packet
	gac_sync_fifo #(
		.WIDTH(1),
		.DEPTH(`GAC_MD_DEPTH),
		.ALF_LEVEL(`GAC_MD_DEPTH)
	) valid_fifo_i (
		.clk(clk), .rst_n(rst_n),
		.wr(in_valid_wr), .wdata(1'b1), .rd(vfifo_rd), .rdata(),
		.empty(vfifo_empty), .full(), .alf()
	);

	gac_sync_fifo #(
		.WIDTH(`GAC_MD_W),
		.DEPTH(`GAC_MD_DEPTH),
		.ALF_LEVEL(`GAC_MD_DEPTH)
	) md_fifo_i (
		.clk(clk), .rst_n(rst_n),
		.wr(in_md_wr), .wdata(in_md), .rd(md_rd), .rdata(md_head),
		.empty(md_empty), .full(md_alf), .alf()
	);

	// ******************************************************************
	// configuration and action table
	// ******************************************************************
	gac_cfg cfg_i (
		.clk(clk), .rst_n(rst_n),
		.cfg_cs(cfg_cs), .cfg_rw(cfg_rw), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.tbl_rdata(tbl_cfg_rdata), .cfg_ack(cfg_ack), .cfg_rdata(cfg_rdata),
		.tbl_wr(tbl_wr), .tbl_addr(tbl_waddr), .tbl_wdata(tbl_wdata)
	);

	gac_action_ram ram_i (
		.clk(clk),
		.cfg_wr(tbl_wr), .cfg_addr(tbl_waddr), .cfg_wdata(tbl_wdata),
		.lookup_addr(tbl_lookup_addr), .cfg_rdata(tbl_cfg_rdata),
		.lookup_rdata(tbl_lookup_rdata)
	);

	gac_exec exec_i (
		.clk(clk), .rst_n(rst_n), .sys_max_cpuid(sys_max_cpuid),
		.vfifo_empty(vfifo_empty), .md_empty(md_empty), .md(md_head),
		.dfifo_rdata(dfifo_rdata), .out_alf(out_alf), .act(tbl_lookup_rdata),
		.vfifo_rd(vfifo_rd), .md_rd(md_rd), .dfifo_rd(dfifo_rd),
		.lookup_addr(tbl_lookup_addr), .out_data(out_data),
		.out_data_wr(out_data_wr), .out_valid_wr(out_valid_wr)
	);

endmodule

// File: verification/gac_tb.sv
// testbench for the action stage with bus setup, packet stimulus, expected queue and checks
`include "gac_consts.svh"

module gac_tb;

	import gac_pkg::*;

	localparam int NUM_PKTS = 10;

	logic clk;
	logic rst_n;
	cpuid_t sys_max_cpuid;
	flit_t in_data;
	logic in_data_wr;
	logic in_valid_wr;
	md_t in_md;
	logic in_md_wr;
	logic data_alf;
	logic md_alf;
	flit_t out_data;
	logic out_data_wr;
	logic out_valid_wr;
	logic out_alf;
	logic cfg_cs;
	logic cfg_rw;
	logic [`GAC_CFG_AW-1:0] cfg_addr;
	logic [`GAC_TBL_DW-1:0] cfg_wdata;
	logic cfg_ack;
	logic [`GAC_TBL_DW-1:0] cfg_rdata;

	integer seed;
	int limit_cycles;
	int pkt_len [NUM_PKTS];
	logic [`GAC_TBL_DW-1:0] tbl_model [0:255];  // entries as written over the bus
	cpuid_t poll_id;                            // expected round-robin cpu id
	logic [`GAC_FLIT_W:0] exp_q [$];            // {last, flit}
	logic [`GAC_FLIT_W:0] exp_head;
	int exp_cnt;
	int flits_sent;                             // flits written into the stage so far
	int pkts_sent;                              // metadata words written so far

	gac_top dut_i (
		.clk(clk), .rst_n(rst_n), .sys_max_cpuid(sys_max_cpuid),
		.in_data(in_data), .in_data_wr(in_data_wr), .in_valid_wr(in_valid_wr),
		.in_md(in_md), .in_md_wr(in_md_wr), .data_alf(data_alf), .md_alf(md_alf),
		.out_data(out_data), .out_data_wr(out_data_wr), .out_valid_wr(out_valid_wr),
		.out_alf(out_alf),
		.cfg_cs(cfg_cs), .cfg_rw(cfg_rw), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.cfg_ack(cfg_ack), .cfg_rdata(cfg_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	function automatic void refresh_head();
		exp_cnt = exp_q.size();
		exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
	endfunction

	task automatic push_exp(input logic last, input flit_t f);
		exp_q.push_back({last, f});
		refresh_head();
	endtask

	// expected queue drops its head as each flit leaves
	always @(posedge clk) begin
		if (rst_n && out_data_wr && (exp_q.size() > 0)) begin
			exp_q.delete(0);
			refresh_head();
		end
	end

	// ******************************************************************
	// output checks
	// ******************************************************************
	a_flit_expected: assert property (@(posedge clk) disable iff (!rst_n)
		out_data_wr |-> exp_cnt != 0)
		else abort_run("output flit appeared while none was expected");

	a_flit_value: assert property (@(posedge clk) disable iff (!rst_n)
		out_data_wr && exp_cnt != 0 |-> out_data == exp_head[`GAC_FLIT_W-1:0])
		else abort_run($sformatf("ERR out_data exp %h got %h",
			$sampled(exp_head[`GAC_FLIT_W-1:0]), $sampled(out_data)));

	a_valid_tail: assert property (@(posedge clk) disable iff (!rst_n)
		out_data_wr && exp_cnt != 0 |-> out_valid_wr == exp_head[`GAC_FLIT_W])
		else abort_run($sformatf("ERR out_valid_wr exp %h got %h",
			$sampled(exp_head[`GAC_FLIT_W]), $sampled(out_valid_wr)));

	a_valid_alone: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid_wr |-> out_data_wr)
		else abort_run("out_valid_wr pulsed without a flit");

	// a fifo cannot hold more words than were ever written into it
	a_data_alf: assert property (@(posedge clk) disable iff (!rst_n)
		flits_sent < `GAC_DATA_ALF |-> !data_alf)
		else abort_run($sformatf("ERR data_alf exp %h got %h", 1'b0, $sampled(data_alf)));

	a_md_alf: assert property (@(posedge clk) disable iff (!rst_n)
		pkts_sent < `GAC_MD_DEPTH |-> !md_alf)
		else abort_run($sformatf("ERR md_alf exp %h got %h", 1'b0, $sampled(md_alf)));

	// ack follows the chip select through the two sync flops
	a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cfg_ack) |-> cfg_cs)
		else abort_run("cfg_ack rose without a chip select");

	a_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
		cfg_ack && cfg_cs && $past(cfg_cs, 3) |=> cfg_ack)
		else abort_run("cfg_ack dropped while the chip select was still high");

	a_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(cfg_cs) |-> ##3 !cfg_ack)
		else abort_run("cfg_ack did not fall after the chip select dropped");

	// ******************************************************************
	// local bus
	// ******************************************************************
	task automatic bus_cycle(input logic rw, input logic [7:0] idx, input logic [31:0] data);
		int n;
		cfg_cs = 1'b1;
		cfg_rw = rw;
		cfg_addr = {6'd0, idx, 2'b00};
		cfg_wdata = data;
		n = 0;
		while (!cfg_ack) begin
			tick();
			n++;
			if (n > 50) abort_run("local bus cycle got no ack");
		end
		if (rw) begin
			assert (cfg_rdata == tbl_model[idx])
				else abort_run($sformatf("ERR cfg_rdata exp %h got %h", tbl_model[idx], cfg_rdata));
		end
		repeat (4) tick(); // hold cs, ack must stay up
		cfg_cs = 1'b0;
		n = 0;
		while (cfg_ack) begin
			tick();
			n++;
			if (n > 50) abort_run("local bus ack never released");
		end
		cfg_rw = 1'b0;
		tick();
	endtask

	task automatic table_write(input logic [7:0] idx, input logic [31:0] data);
		bus_cycle(1'b0, idx, data);
		tbl_model[idx] = data;
	endtask

	// ******************************************************************
	// packets
	// ******************************************************************
	function automatic flit_t meta_flit(input flit_t first, input md_t md,
		input logic [31:0] entry, input cpuid_t poll);
		md_t m;
		m = md;
		m[`GAC_MD_DMID] = `GAC_NMID;
		case (entry[31:28])
			`GAC_ACT_CPU: begin
				m[`GAC_MD_PKTDST] = 1'b1;
				m[`GAC_MD_OUTTYPE] = 2'b01;
				m[`GAC_MD_OUTPORT] = entry[5:0];
			end
			`GAC_ACT_POLL: begin
				m[`GAC_MD_PKTDST] = 1'b1;
				m[`GAC_MD_OUTTYPE] = 2'b10;
				m[`GAC_MD_OUTPORT] = poll;
			end
			`GAC_ACT_PORT: begin
				m[`GAC_MD_PKTDST] = 1'b0;
				m[`GAC_MD_OUTTYPE] = 2'b00;
				m[`GAC_MD_OUTPORT] = entry[5:0];
			end
			default: begin // new destination, outport untouched
				m[`GAC_MD_PKTDST] = 1'b1;
				m[`GAC_MD_OUTTYPE] = 2'b00;
				m[`GAC_MD_DMID] = entry[7:0];
			end
		endcase
		return {first[133:128], m};
	endfunction

	task automatic send_packet(input logic [7:0] dmid, input logic [7:0] idx, input int len);
		flit_t flits [$];
		flit_t f;
		logic [159:0] bits;
		md_t md;
		logic [31:0] entry;
		logic [3:0] act;
		logic fwd;
		md = {$random(seed), $random(seed), $random(seed), $random(seed)};
		md[`GAC_MD_DMID] = dmid;
		md[`GAC_MD_INDEX] = idx;
		for (int i = 0; i < len; i++) begin
			bits = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
			f = {2'b00, bits[131:0]};
			if (i == 0) f[`GAC_FLIT_TAG] = 2'b01;
			if (i == len - 1) f[`GAC_FLIT_TAG] = `GAC_TAG_TAIL;
			flits.push_back(f);
		end
		fwd = 1'b1;
		if (dmid == `GAC_LMID) begin
			entry = tbl_model[idx];
			act = entry[31:28];
			if (act >= `GAC_ACT_CPU && act <= `GAC_ACT_MID) begin
				push_exp(1'b0, meta_flit(flits[0], md, entry, poll_id));
			end else begin
				fwd = 1'b0; // dropped
			end
			if (act == `GAC_ACT_POLL) begin
				poll_id = ((poll_id + 7'd1) >= sys_max_cpuid) ? '0 : poll_id + 1'b1;
			end
		end
		if (fwd) begin
			for (int i = 0; i < len; i++) push_exp(i == len - 1, flits[i]);
		end
		while (data_alf || md_alf) tick();
		for (int i = 0; i < len; i++) begin
			in_data = flits[i];
			in_data_wr = 1'b1;
			flits_sent++;
			if (i == len - 1) begin // packet complete, queue md and valid
				in_md = md;
				in_md_wr = 1'b1;
				in_valid_wr = 1'b1;
				pkts_sent++;
			end
			tick();
		end
		in_data_wr = 1'b0;
		in_md_wr = 1'b0;
		in_valid_wr = 1'b0;
	endtask

	// watchdog sized by the stimulus length
	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk);
		abort_run("timeout, the run did not finish in the expected time");
	end

	initial begin
		int total;
		rst_n = 1'b0;
		sys_max_cpuid = 6'd3;
		in_data = '0;
		in_data_wr = 1'b0;
		in_valid_wr = 1'b0;
		in_md = '0;
		in_md_wr = 1'b0;
		out_alf = 1'b0;
		cfg_cs = 1'b0;
		cfg_rw = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		poll_id = '0;
		flits_sent = 0;
		pkts_sent = 0;
		refresh_head();
		seed = 32'he561_0944;
		total = 0;
		for (int i = 0; i < NUM_PKTS; i++) begin
			pkt_len[i] = 2 + ({$random(seed)} % 5);
			total += pkt_len[i];
		end
		limit_cycles = total * 20 + 2000;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		tick();

		table_write(8'h10, 32'h3000_0009); // to port 9
		table_write(8'h11, 32'h2000_0000); // round robin cpu
		table_write(8'h12, 32'h1000_002a); // cpu port 42
		table_write(8'h13, 32'h4000_0077); // new dmid 0x77
		table_write(8'h14, 32'h0abc_def0); // no action, drop
		for (int i = 8'h10; i <= 8'h14; i++) bus_cycle(1'b1, i[7:0], 32'h0);

		send_packet(`GAC_LMID, 8'h10, pkt_len[0]);
		for (int k = 1; k <= 4; k++) send_packet(`GAC_LMID, 8'h11, pkt_len[k]);
		send_packet(`GAC_LMID, 8'h12, pkt_len[5]);
		send_packet(`GAC_LMID, 8'h13, pkt_len[6]);
		send_packet(`GAC_LMID, 8'h14, pkt_len[7]);
		send_packet(`GAC_LMID, 8'h10, pkt_len[8]);
		send_packet(8'h09, 8'h12, pkt_len[9]);  // not for this stage

		while (exp_cnt != 0) tick();
		repeat (20) tick(); // nothing more may come out
		$display("All checks passed");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+hdl
hdl/gac_pkg.sv
hdl/gac_sync_fifo.sv
hdl/gac_cfg.sv
hdl/gac_action_ram.sv
hdl/gac_exec.sv
hdl/gac_top.sv
verification/gac_tb.sv

// File: Bender.yml
package:
  name: gac

export_include_dirs:
  - hdl

sources:
  - hdl/gac_pkg.sv
  - hdl/gac_sync_fifo.sv
  - hdl/gac_cfg.sv
  - hdl/gac_action_ram.sv
  - hdl/gac_exec.sv
  - hdl/gac_top.sv
  - target: simulation
    files:
      - verification/gac_tb.sv
